// ==== Makefile ====
SIM := obj_dir/Vu2_ctrl_tb
SRCS := $(wildcard hdl/*.sv dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module u2_ctrl_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_clkgen.sv ====
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
   output logic dsp_clk,
   output logic arst_n_o
);

   // 4 ns period
   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   // Reset held for 16 cycles, released just after an edge
   initial begin
      arst_n_o = 1'b0;
      repeat (16) @(posedge dsp_clk);
      #1;
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== dv/u2_ctrl_tb.sv ====
//////////////////////////////
// Directed tests for the control core
// Wishbone tasks, compare tasks, summary
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module u2_ctrl_tb;
   import u2_ctrl_pkg::*;

   localparam int          ACK_TIMEOUT = 16;
   localparam logic [15:0] RB_WIN      = 16'd1 << READBACK_BIT;

   logic        dsp_clk;
   logic        arst_n;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic        pps;
   hw_status_t  hw_status;
   logic [7:0]  leds;
   ctrl_pins_t  ctrl_pins;
   logic [31:0] rng_state = 32'hf68f;
   int          err_cnt = 0;
   int          test_cnt = 0;
   // Shadow copies of the misc registers
   logic [4:0]  sh_clk;
   logic [3:0]  sh_ser;
   logic [3:0]  sh_adc;
   logic        sh_phy;
   logic [7:0]  sh_led_sw;
   logic [7:0]  sh_led_src;

   tb_clkgen i_tb_clkgen (.dsp_clk(dsp_clk), .arst_n_o(arst_n));

   u2_ctrl_top #(.TICKS_PER_SEC(32'd1000)) i_u2_ctrl_top (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .pps_i(pps), .hw_status_i(hw_status), .leds_o(leds), .ctrl_pins_o(ctrl_pins));

   //////////////////////////////
   // Reference models

   function automatic logic [31:0] rand_next();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic ctrl_pins_t pins_expect();
      ctrl_pins_t p;
      p.clock_ready = sh_clk[4];
      p.clk_en      = sh_clk[3:2];
      p.clk_sel     = sh_clk[1:0];
      p.ser_enable  = sh_ser[3];
      p.ser_prbsen  = sh_ser[2];
      p.ser_loopen  = sh_ser[1];
      p.ser_rx_en   = sh_ser[0];
      p.adc_oe_a    = sh_adc[3];
      p.adc_on_a    = sh_adc[2];
      p.adc_oe_b    = sh_adc[1];
      p.adc_on_b    = sh_adc[0];
      p.phy_reset_n = !sh_phy;
      return p;
   endfunction

   // Per bit, source set shows hardware, clear shows software
   function automatic logic [7:0] leds_expect();
      logic [7:0] hw;
      logic [7:0] e;
      hw    = 8'h00;
      hw[4] = hw_status.run_tx;
      hw[3] = hw_status.run_rx;
      hw[2] = hw_status.clk_status;
      hw[1] = hw_status.link_up;
      for (int i = 0; i < 8; i++)
         e[i] = sh_led_src[i] ? hw[i] : sh_led_sw[i];
      return e;
   endfunction

   function automatic vita_time_t mk_time(input logic [31:0] secs, input logic [31:0] ticks);
      vita_time_t t;
      t.secs  = secs;
      t.ticks = ticks;
      return t;
   endfunction

   //////////////////////////////
   // Compare tasks

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %t: %s got %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_leds(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("Error at %t: %s got %b, expected %b", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_pins(input string what, input ctrl_pins_t got, input ctrl_pins_t exp);
      if (got !== exp) begin
         $display("Error at %t: %s got %b, expected %b", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   // Strict ordering of two time values
   task automatic check_order(input string what, input vita_time_t a, input vita_time_t b);
      if (!(a < b)) begin
         $display("Error at %t: %s %h not below %h", $time, what, a, b);
         err_cnt++;
      end
   endtask

   //////////////////////////////
   // Bus tasks

   task automatic step(input int n);
      repeat (n) @(posedge dsp_clk);
      #1;
   endtask

   task automatic wb_cycle(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
      int waited;
      rdat = 32'd0;
      waited = 0;
      step(1);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      wb_req.sel = 4'hf;
      step(1);
      while (!wb_rsp.ack && waited < ACK_TIMEOUT) begin
         step(1);
         waited++;
      end
      if (wb_rsp.ack) begin
         rdat = wb_rsp.dat;
      end else begin
         $display("Bus transfer to address %h was never acknowledged", adr);
         err_cnt++;
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat);
      logic [31:0] unused_rd;
      wb_cycle(1'b1, adr, dat, unused_rd);
   endtask

   task automatic wb_read(input logic [15:0] adr, output logic [31:0] dat);
      wb_cycle(1'b0, adr, 32'd0, dat);
   endtask

   task automatic set_reg(input logic [7:0] addr, input logic [31:0] dat);
      wb_write({6'd0, addr, 2'b00}, dat);
   endtask

   task automatic rb_read(input logic [3:0] idx, output logic [31:0] dat);
      wb_read(RB_WIN | {10'd0, idx, 2'b00}, dat);
   endtask

   task automatic read_time(input logic [3:0] idx_secs, output vita_time_t t);
      logic [31:0] s;
      logic [31:0] k;
      rb_read(idx_secs, s);
      rb_read(idx_secs + 4'd1, k);
      t = mk_time(s, k);
   endtask

   task automatic finish_test(input string name, input int e0);
      test_cnt++;
      $display("Test %s finished with %0d errors", name, err_cnt - e0);
   endtask

   //////////////////////////////
   // Tests

   task automatic test_reset();
      int          e0;
      logic [31:0] rd;
      e0 = err_cnt;
      rb_read(RB_COMPAT, rd);
      check_word("compat number", rd, U2_COMPAT_NUM);
      check_pins("pins after reset", ctrl_pins, pins_expect());
      check_leds("leds after reset", leds, leds_expect());
      finish_test("reset", e0);
   endtask

   task automatic test_misc();
      int          e0;
      logic [31:0] r;
      e0 = err_cnt;
      for (int n = 0; n < 8; n++) begin
         r = rand_next();
         sh_clk = r[4:0];
         set_reg(SR_MISC + OFS_CLK, r);
         r = rand_next();
         sh_ser = r[3:0];
         set_reg(SR_MISC + OFS_SER, r);
         r = rand_next();
         sh_adc = r[3:0];
         set_reg(SR_MISC + OFS_ADC, r);
         r = rand_next();
         sh_phy = r[0];
         set_reg(SR_MISC + OFS_PHY, r);
         step(1);
         check_pins("misc pins", ctrl_pins, pins_expect());
      end
      // Offset 5 is a hole in the map
      set_reg(SR_MISC + 8'd5, rand_next());
      step(1);
      check_pins("pins after unused offset", ctrl_pins, pins_expect());
      check_leds("leds after unused offset", leds, leds_expect());
      finish_test("misc_regs", e0);
   endtask

   task automatic test_leds();
      int          e0;
      logic [31:0] r;
      e0 = err_cnt;
      for (int n = 0; n < 8; n++) begin
         r = rand_next();
         sh_led_sw  = r[7:0];
         sh_led_src = r[15:8];
         hw_status  = r[19:16];
         set_reg(SR_MISC + OFS_LED_SW, {24'd0, sh_led_sw});
         set_reg(SR_MISC + OFS_LED_SRC, {24'd0, sh_led_src});
         step(1);
         check_leds("led mux", leds, leds_expect());
      end
      finish_test("led_mux", e0);
   endtask

   task automatic test_time();
      int          e0;
      logic [31:0] s;
      logic [31:0] rd;
      vita_time_t  t;
      e0 = err_cnt;
      s = rand_next();
      set_reg(SR_TIME64 + OFS_SECS, s);
      set_reg(SR_TIME64 + OFS_TICKS, 32'd10);
      read_time(RB_SECS, t);
      check_word("secs after load", t.secs, s);
      check_order("ticks after load", mk_time(s, 32'd10), t);
      check_order("ticks after load", t, mk_time(s, 32'd301));
      // Two ticks short of the wrap
      s = rand_next();
      set_reg(SR_TIME64 + OFS_SECS, s);
      set_reg(SR_TIME64 + OFS_TICKS, 32'd998);
      step(20);
      rb_read(RB_SECS, rd);
      check_word("secs after wrap", rd, s + 32'd1);
      finish_test("time_count", e0);
   endtask

   task automatic test_pps();
      int          e0;
      logic [31:0] s;
      vita_time_t  t0;
      vita_time_t  snap;
      vita_time_t  t1;
      e0 = err_cnt;
      s = rand_next();
      set_reg(SR_TIME64 + OFS_SECS, s);
      set_reg(SR_TIME64 + OFS_TICKS, 32'd100);
      read_time(RB_SECS, t0);
      pps = 1'b1;
      step(4);
      pps = 1'b0;
      step(10);
      read_time(RB_PPS_SECS, snap);
      read_time(RB_SECS, t1);
      check_order("snapshot after t0", t0, snap);
      check_order("t1 after snapshot", snap, t1);
      check_word("snapshot second", snap.secs, t0.secs);
      check_word("t1 second", t1.secs, t0.secs);
      finish_test("pps_capture", e0);
   endtask

   task automatic test_windows();
      int          e0;
      logic [31:0] s;
      logic [31:0] r;
      logic [31:0] rd;
      logic [31:0] pps_secs;
      logic [31:0] exp;
      e0 = err_cnt;
      s = rand_next();
      set_reg(SR_TIME64 + OFS_SECS, s);
      set_reg(SR_TIME64 + OFS_TICKS, 32'd0);
      rb_read(RB_PPS_SECS, pps_secs);
      // Readback addresses whose word bits alias settings registers
      wb_write(RB_WIN | {6'd0, SR_MISC + OFS_CLK, 2'b00}, rand_next());
      wb_write(RB_WIN | {6'd0, SR_MISC + OFS_LED_SRC, 2'b00}, rand_next());
      wb_write(RB_WIN | {6'd0, SR_TIME64 + OFS_SECS, 2'b00}, rand_next());
      wb_write(RB_WIN | {6'd0, SR_TIME64 + OFS_TICKS, 2'b00}, 32'd500);
      step(1);
      check_pins("pins after readback write", ctrl_pins, pins_expect());
      check_leds("leds after readback write", leds, leds_expect());
      rb_read(RB_SECS, rd);
      check_word("secs after readback write", rd, s);
      rb_read(RB_PPS_SECS, rd);
      check_word("snapshot after readback write", rd, pps_secs);
      rb_read(RB_COMPAT, rd);
      check_word("compat after readback write", rd, U2_COMPAT_NUM);
      for (int i = 6; i < 16; i++) begin
         rb_read(i[3:0], rd);
         check_word("unused readback slot", rd, 32'd0);
      end
      for (int n = 0; n < 4; n++) begin
         r = rand_next();
         hw_status = r[3:0];
         exp = 32'd0;
         exp[11] = hw_status.clk_status;
         exp[10] = hw_status.link_up;
         rb_read(RB_STATUS, rd);
         check_word("status word", rd, exp);
      end
      // Word bits here select the compatibility slot
      wb_read({6'd0, SR_MISC + OFS_CLK, 2'b00}, rd);
      check_word("settings window read", rd, 32'd0);
      finish_test("windows", e0);
   endtask

   //////////////////////////////
   // Sequence

   initial begin
      int waited;
      $timeformat(-9, 1, " ns", 0);
      wb_req     = '0;
      pps        = 1'b0;
      hw_status  = 4'b1010;
      sh_clk     = '0;
      sh_ser     = '0;
      sh_adc     = '0;
      sh_phy     = 1'b0;
      sh_led_sw  = '0;
      sh_led_src = LED_SRC_RESET;
      waited     = 0;
      while (arst_n !== 1'b1 && waited < 100) begin
         @(posedge dsp_clk);
         waited++;
      end
      if (arst_n !== 1'b1) begin
         $display("Reset was never released");
         err_cnt++;
      end
      step(1);
      test_reset();
      test_misc();
      test_leds();
      test_time();
      test_pps();
      test_windows();
      $display("Tests run %0d, errors %0d", test_cnt, err_cnt);
      if (err_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // Whole-run limit
   initial begin
      repeat (20000) @(posedge dsp_clk);
      $display("Watchdog expired before the tests finished");
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/front_panel_out.sv ====
//////////////////////////////
// LED source mux
// Control pin drive from setting fields
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module front_panel_out (
   input  wire [7:0]                     led_sw_i,
   input  wire [7:0]                     led_src_i,
   input  wire u2_ctrl_pkg::hw_status_t  hw_status_i,
   input  wire [4:0]                     clk_reg_i,
   input  wire [3:0]                     ser_reg_i,
   input  wire [3:0]                     adc_reg_i,
   input  wire                           phy_reset_i,
   output logic [7:0]                    leds_o,
   output u2_ctrl_pkg::ctrl_pins_t       ctrl_pins_o
);

   logic [7:0] led_hw;

   assign led_hw = {3'b000, hw_status_i.run_tx, hw_status_i.run_rx,
                    hw_status_i.clk_status, hw_status_i.link_up, 1'b0};

   // Source bit set picks hardware, clear picks software
   assign leds_o = (led_src_i & led_hw) | (~led_src_i & led_sw_i);

   //////////////////////////////
   // Pin unpacking, high bit first

   assign {ctrl_pins_o.clock_ready, ctrl_pins_o.clk_en, ctrl_pins_o.clk_sel} = clk_reg_i;

   assign {ctrl_pins_o.ser_enable, ctrl_pins_o.ser_prbsen,
           ctrl_pins_o.ser_loopen, ctrl_pins_o.ser_rx_en} = ser_reg_i;

   assign {ctrl_pins_o.adc_oe_a, ctrl_pins_o.adc_on_a,
           ctrl_pins_o.adc_oe_b, ctrl_pins_o.adc_on_b} = adc_reg_i;

   // Register holds reset asserted, pin is active low
   assign ctrl_pins_o.phy_reset_n = ~phy_reset_i;

endmodule

`default_nettype wire

// ==== hdl/misc_setting_regs.sv ====
//////////////////////////////
// Misc setting registers
// Clock gen, SERDES, ADC, PHY reset, LED values
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module misc_setting_regs #(
   parameter logic [7:0] MISC_BASE = u2_ctrl_pkg::SR_MISC
) (
   input  wire                         dsp_clk,
   input  wire                         arst_n_i,
   input  wire u2_ctrl_pkg::set_bus_t  set_bus_i,
   output logic [4:0]                  clk_reg_o,
   output logic [3:0]                  ser_reg_o,
   output logic [3:0]                  adc_reg_o,
   output logic                        phy_reset_o,
   output logic [7:0]                  led_sw_o,
   output logic [7:0]                  led_src_o
);
   import u2_ctrl_pkg::*;

   logic [31:0] wr_data;

   assign wr_data = set_bus_i.data;

   // One cycle from strobe to register output
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         clk_reg_o   <= '0;
         ser_reg_o   <= '0;
         adc_reg_o   <= '0;
         phy_reset_o <= 1'b0;
         led_sw_o    <= '0;
         // Hardware drives LEDs 4 to 1 out of reset
         led_src_o   <= LED_SRC_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            MISC_BASE + OFS_CLK: begin
               clk_reg_o <= wr_data[4:0];
            end
            MISC_BASE + OFS_SER: begin
               ser_reg_o <= wr_data[3:0];
            end
            MISC_BASE + OFS_ADC: begin
               adc_reg_o <= wr_data[3:0];
            end
            MISC_BASE + OFS_LED_SW: begin
               led_sw_o <= wr_data[7:0];
            end
            MISC_BASE + OFS_PHY: begin
               phy_reset_o <= wr_data[0];
            end
            MISC_BASE + OFS_LED_SRC: begin
               led_src_o <= wr_data[7:0];
            end
            // Offset 5 and anything outside the block
            default: begin
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/status_readback.sv ====
//////////////////////////////
// Readback words and index select
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module status_readback (
   input  wire [3:0]                     rb_index_i,
   input  wire u2_ctrl_pkg::vita_time_t  time_i,
   input  wire u2_ctrl_pkg::vita_time_t  pps_time_i,
   input  wire u2_ctrl_pkg::hw_status_t  hw_status_i,
   output logic [31:0]                   rb_word_o
);
   import u2_ctrl_pkg::*;

   logic [31:0] status_word;

   // Clock status at bit 11, link at bit 10
   assign status_word = {20'd0, hw_status_i.clk_status, hw_status_i.link_up, 10'd0};

   always_comb begin
      case (rb_index_i)
         RB_COMPAT:    rb_word_o = U2_COMPAT_NUM;
         RB_SECS:      rb_word_o = time_i.secs;
         RB_TICKS:     rb_word_o = time_i.ticks;
         RB_PPS_SECS:  rb_word_o = pps_time_i.secs;
         RB_PPS_TICKS: rb_word_o = pps_time_i.ticks;
         RB_STATUS:    rb_word_o = status_word;
         // Unused slots 6 to 15
         default:      rb_word_o = 32'd0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/u2_ctrl_pkg.sv ====
//////////////////////////////
// Bus, time and pin bundles
// Settings address map and readback indices
// Compatibility number and default parameters
//////////////////////////////
`default_nettype none

package u2_ctrl_pkg;

   //////////////////////////////
   // Bundles

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;   // byte address
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic link_up;
   } hw_status_t;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } ctrl_pins_t;

   //////////////////////////////
   // Settings register map

   localparam logic [7:0] SR_MISC      = 8'd0;
   localparam logic [7:0] OFS_CLK      = 8'd0;
   localparam logic [7:0] OFS_SER      = 8'd1;
   localparam logic [7:0] OFS_ADC      = 8'd2;
   localparam logic [7:0] OFS_LED_SW   = 8'd3;
   localparam logic [7:0] OFS_PHY      = 8'd4;
   localparam logic [7:0] OFS_LED_SRC  = 8'd6;

   localparam logic [7:0] SR_TIME64    = 8'd10;
   localparam logic [7:0] OFS_SECS     = 8'd0;
   localparam logic [7:0] OFS_TICKS    = 8'd1;

   //////////////////////////////
   // Readback window

   localparam logic [3:0] RB_COMPAT    = 4'd0;
   localparam logic [3:0] RB_SECS      = 4'd1;
   localparam logic [3:0] RB_TICKS     = 4'd2;
   localparam logic [3:0] RB_PPS_SECS  = 4'd3;
   localparam logic [3:0] RB_PPS_TICKS = 4'd4;
   localparam logic [3:0] RB_STATUS    = 4'd5;
   localparam int         READBACK_BIT = 10;

   // Major 9, minor 0
   localparam logic [31:0] U2_COMPAT_NUM     = 32'h0009_0000;
   localparam logic [7:0]  LED_SRC_RESET     = 8'h1e;
   localparam logic [31:0] DEF_TICKS_PER_SEC = 32'd100_000_000;

endpackage

`default_nettype wire

// ==== hdl/u2_ctrl_top.sv ====
//////////////////////////////
// Control and status core top level
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module u2_ctrl_top #(
   parameter logic [31:0] TICKS_PER_SEC = u2_ctrl_pkg::DEF_TICKS_PER_SEC
) (
   input  wire                          dsp_clk,
   input  wire                          arst_n_i,
   input  wire u2_ctrl_pkg::wb_req_t    wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t         wb_rsp_o,
   input  wire                          pps_i,
   input  wire u2_ctrl_pkg::hw_status_t hw_status_i,
   output logic [7:0]                   leds_o,
   output u2_ctrl_pkg::ctrl_pins_t      ctrl_pins_o
);
   import u2_ctrl_pkg::*;

   set_bus_t    set_bus;
   vita_time_t  vita_time;
   vita_time_t  vita_time_pps;
   logic [3:0]  rb_index;
   logic [31:0] rb_word;
   logic [4:0]  clk_reg;
   logic [3:0]  ser_reg;
   logic [3:0]  adc_reg;
   logic        phy_reset;
   logic [7:0]  led_sw;
   logic [7:0]  led_src;

   //////////////////////////////
   // Bus side

   wb_settings_port i_wb_settings_port (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i),
      .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
      .set_bus_o(set_bus), .rb_index_o(rb_index), .rb_word_i(rb_word));

   status_readback i_status_readback (
      .rb_index_i(rb_index), .time_i(vita_time), .pps_time_i(vita_time_pps),
      .hw_status_i(hw_status_i), .rb_word_o(rb_word));

   //////////////////////////////
   // Settings consumers

   misc_setting_regs #(.MISC_BASE(SR_MISC)) i_misc_setting_regs (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_bus_i(set_bus),
      .clk_reg_o(clk_reg), .ser_reg_o(ser_reg), .adc_reg_o(adc_reg),
      .phy_reset_o(phy_reset), .led_sw_o(led_sw), .led_src_o(led_src));

   vita_timer #(.TIME_BASE(SR_TIME64), .TICKS_PER_SEC(TICKS_PER_SEC)) i_vita_timer (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_bus_i(set_bus), .pps_i(pps_i),
      .time_o(vita_time), .pps_time_o(vita_time_pps));

   front_panel_out i_front_panel_out (
      .led_sw_i(led_sw), .led_src_i(led_src), .hw_status_i(hw_status_i),
      .clk_reg_i(clk_reg), .ser_reg_i(ser_reg), .adc_reg_i(adc_reg),
      .phy_reset_i(phy_reset), .leds_o(leds_o), .ctrl_pins_o(ctrl_pins_o));

endmodule

`default_nettype wire

// ==== hdl/vita_timer.sv ====
//////////////////////////////
// Seconds and ticks counter
// Settings load, PPS sync and snapshot
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module vita_timer #(
   parameter logic [7:0]  TIME_BASE     = u2_ctrl_pkg::SR_TIME64,
   parameter logic [31:0] TICKS_PER_SEC = u2_ctrl_pkg::DEF_TICKS_PER_SEC
) (
   input  wire                         dsp_clk,
   input  wire                         arst_n_i,
   input  wire u2_ctrl_pkg::set_bus_t  set_bus_i,
   input  wire                         pps_i,
   output u2_ctrl_pkg::vita_time_t     time_o,
   output u2_ctrl_pkg::vita_time_t     pps_time_o
);
   import u2_ctrl_pkg::*;

   logic        secs_wr;
   logic        ticks_wr;
   logic [31:0] secs_pend;
   logic [2:0]  pps_sync;   // two sync flops, then the edge reference
   logic        pps_rise;

   assign secs_wr  = set_bus_i.stb && (set_bus_i.addr == TIME_BASE + OFS_SECS);
   assign ticks_wr = set_bus_i.stb && (set_bus_i.addr == TIME_BASE + OFS_TICKS);
   assign pps_rise = pps_sync[1] & ~pps_sync[2];

   //////////////////////////////
   // Time counter

   // SECS is held until the TICKS write commits both halves
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         secs_pend <= '0;
         time_o    <= '0;
      end else begin
         if (secs_wr)
            secs_pend <= set_bus_i.data;
         if (ticks_wr) begin
            time_o.secs  <= secs_pend;
            time_o.ticks <= set_bus_i.data;
         end else if (time_o.ticks == TICKS_PER_SEC - 1) begin
            time_o.ticks <= '0;
            time_o.secs  <= time_o.secs + 32'd1;
         end else begin
            time_o.ticks <= time_o.ticks + 32'd1;
         end
      end
   end

   //////////////////////////////
   // PPS capture

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pps_sync   <= '0;
         pps_time_o <= '0;
      end else begin
         pps_sync <= {pps_sync[1:0], pps_i};
         if (pps_rise)
            pps_time_o <= time_o;
      end
   end

   // Wrap keeps the tick count inside one second
   a_ticks_range : assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      time_o.ticks < TICKS_PER_SEC);

endmodule

`default_nettype wire

// ==== hdl/wb_settings_port.sv ====
//////////////////////////////
// Wishbone classic slave
// Settings writes and readback reads
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module wb_settings_port (
   input  wire                        dsp_clk,
   input  wire                        arst_n_i,
   input  wire u2_ctrl_pkg::wb_req_t  wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t       wb_rsp_o,
   output u2_ctrl_pkg::set_bus_t      set_bus_o,
   output logic [3:0]                 rb_index_o,
   input  wire [31:0]                 rb_word_i
);
   import u2_ctrl_pkg::*;

   logic        req_new;
   logic        rb_window;
   logic        ack_q;
   logic        stb_q;
   logic [7:0]  addr_q;
   logic [31:0] wdata_q;
   logic [31:0] rdata_q;

   // Accept only while ack is low, one transfer per request
   assign req_new    = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
   assign rb_window  = wb_req_i.adr[READBACK_BIT];
   assign rb_index_o = wb_req_i.adr[5:2];

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_q <= req_new;
         // Writes into the readback window are acked and dropped
         stb_q <= req_new & wb_req_i.we & ~rb_window;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (req_new) begin
         addr_q  <= wb_req_i.adr[9:2];
         wdata_q <= wb_req_i.dat;
         // Settings window reads back as zero
         rdata_q <= (rb_window && !wb_req_i.we) ? rb_word_i : 32'd0;
      end
   end

   assign wb_rsp_o  = '{ack: ack_q, dat: rdata_q};
   assign set_bus_o = '{stb: stb_q, addr: addr_q, data: wdata_q};

   //////////////////////////////
   // Protocol checks

   // A held request sees a gap before its next ack
   a_ack_gap : assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      ack_q |=> !ack_q);

   // Every ack answers cyc and stb from the cycle before
   a_ack_req : assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      ack_q |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

// ==== src.f ====
hdl/u2_ctrl_pkg.sv
hdl/wb_settings_port.sv
hdl/misc_setting_regs.sv
hdl/vita_timer.sv
hdl/status_readback.sv
hdl/front_panel_out.sv
hdl/u2_ctrl_top.sv
dv/tb_clkgen.sv
dv/u2_ctrl_tb.sv
